/* rtl/line_bridge_pkg.sv */
// Shared widths and helpers for the word-to-line memory subsystem.
// The word port is fixed at 64 bits; line size is a module parameter.
// Burst address stepping wraps inside a 4 KB page.

package line_bridge_pkg;

    localparam int WORD_BITS = 64;
    localparam int ADDR_BITS = 32;
    localparam int ID_BITS   = 4;
    localparam int LEN_BITS  = 8;
    localparam int SIZE_BITS = 3;

    // Bridge FSM states
    typedef enum logic [3:0] {
        idle,
        write_data_accept,
        read_line_request,
        wait_read_line,
        write_line_request,
        wait_write_confirm,
        wait_write_accept,
        wait_read_accept,
        check_burst
    } bridge_state_e;

    // Bytes per beat for an AXI size code, sized for the 12-bit page offset
    function automatic logic [11:0] size_to_bytes(input logic [SIZE_BITS-1:0] size);
        return 12'd1 << size;
    endfunction

endpackage

/* rtl/line_bus_if.sv */
// Cache-line request/response bus between the bridge and the line store.
// Addresses are line aligned; address and data of a line write travel together.
// No id field, one transaction is in flight at a time.

`timescale 1ns/1ps

interface line_bus_if #(
    parameter int LINE_BYTES = 32
);

    // Line read request and response
    logic                                 ar_valid;
    logic                                 ar_ready;
    logic [line_bridge_pkg::ADDR_BITS-1:0] ar_addr;
    logic                                 r_valid;
    logic                                 r_ready;
    logic [LINE_BYTES*8-1:0]              r_data;

    // Line write and its confirm
    logic                                 aw_valid;
    logic                                 aw_ready;
    logic [line_bridge_pkg::ADDR_BITS-1:0] aw_addr;
    logic                                 w_valid;
    logic                                 w_ready;
    logic [LINE_BYTES*8-1:0]              w_data;
    logic [LINE_BYTES-1:0]                w_strb;
    logic                                 b_valid;
    logic                                 b_ready;

    modport bridge (
        output ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        input  ar_ready, r_valid, r_data, aw_ready, w_ready, b_valid
    );

    modport store (
        input  ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        output ar_ready, r_valid, r_data, aw_ready, w_ready, b_valid
    );

endinterface

/* rtl/word_to_line_bridge.sv */
// Converts 64-bit AXI-style word accesses into whole-line accesses.
// One transaction at a time; a write is a line read, merge and line write-back.
// INCR bursts only, stepped per beat inside a 4 KB page. Response is always OKAY.
// LINE_BYTES must be a power of two of at least 16.

`timescale 1ns/1ps

module word_to_line_bridge #(
    parameter int LINE_BYTES = 32
) (
    input  logic                                  i_clk,
    input  logic                                  i_nrst,
    input  logic                                  i_aw_valid,
    output logic                                  o_aw_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]   i_aw_id,
    input  logic [line_bridge_pkg::ADDR_BITS-1:0] i_aw_addr,
    input  logic [line_bridge_pkg::SIZE_BITS-1:0] i_aw_size,
    input  logic [line_bridge_pkg::LEN_BITS-1:0]  i_aw_len,
    input  logic                                  i_w_valid,
    output logic                                  o_w_ready,
    input  logic [line_bridge_pkg::WORD_BITS-1:0] i_w_data,
    input  logic [line_bridge_pkg::WORD_BITS/8-1:0] i_w_strb,
    output logic                                  o_b_valid,
    input  logic                                  i_b_ready,
    output logic [line_bridge_pkg::ID_BITS-1:0]   o_b_id,
    input  logic                                  i_ar_valid,
    output logic                                  o_ar_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]   i_ar_id,
    input  logic [line_bridge_pkg::ADDR_BITS-1:0] i_ar_addr,
    input  logic [line_bridge_pkg::SIZE_BITS-1:0] i_ar_size,
    input  logic [line_bridge_pkg::LEN_BITS-1:0]  i_ar_len,
    output logic                                  o_r_valid,
    input  logic                                  i_r_ready,
    output logic [line_bridge_pkg::ID_BITS-1:0]   o_r_id,
    output logic [line_bridge_pkg::WORD_BITS-1:0] o_r_data,
    output logic                                  o_r_last,
    line_bus_if.bridge                            line
);

    localparam int WB       = line_bridge_pkg::WORD_BITS;
    localparam int AB       = line_bridge_pkg::ADDR_BITS;
    localparam int LINE_OFF = $clog2(LINE_BYTES);
    localparam int IDX_BITS = LINE_OFF - 3;

    line_bridge_pkg::bridge_state_e state;

    logic                                  writing;
    logic                                  rmw;
    logic [line_bridge_pkg::LEN_BITS-1:0]  req_len;
    logic [line_bridge_pkg::ID_BITS-1:0]   req_id;
    logic [AB-1:0]                         req_addr;
    logic [line_bridge_pkg::SIZE_BITS-1:0] req_size;
    logic [WB-1:0]                         req_wdata;
    logic [WB/8-1:0]                       req_wstrb;
    logic [LINE_BYTES*8-1:0]               line_data;
    logic [WB-1:0]                         resp_data;
    logic [IDX_BITS-1:0]                   word_idx;
    logic [LINE_BYTES*8-1:0]               merged_line;

    assign word_idx = req_addr[LINE_OFF-1:3];

    // Word port side, all driven from the state
    assign o_aw_ready = (state == line_bridge_pkg::idle);
    assign o_ar_ready = (state == line_bridge_pkg::idle);
    assign o_w_ready  = (state == line_bridge_pkg::write_data_accept);
    assign o_b_valid  = (state == line_bridge_pkg::wait_write_accept);
    assign o_b_id     = req_id;
    assign o_r_valid  = (state == line_bridge_pkg::wait_read_accept);
    assign o_r_id     = req_id;
    assign o_r_data   = resp_data;
    assign o_r_last   = (req_len == '0);

    // Line bus side, always on the aligned line address
    assign line.ar_valid = (state == line_bridge_pkg::read_line_request);
    assign line.ar_addr  = {req_addr[AB-1:LINE_OFF], {LINE_OFF{1'b0}}};
    assign line.r_ready  = (state == line_bridge_pkg::wait_read_line);
    assign line.aw_valid = (state == line_bridge_pkg::write_line_request);
    assign line.w_valid  = (state == line_bridge_pkg::write_line_request);
    assign line.aw_addr  = {req_addr[AB-1:LINE_OFF], {LINE_OFF{1'b0}}};
    assign line.w_data   = line_data;
    assign line.w_strb   = '1;
    assign line.b_ready  = (state == line_bridge_pkg::wait_write_confirm);

    // Strobed bytes of the held word replace the same bytes of its slot
    always_comb begin
        merged_line = line.r_data;
        for (int b = 0; b < WB / 8; b++) begin
            if (req_wstrb[b]) begin
                merged_line[word_idx*WB + b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= line_bridge_pkg::idle;
            writing <= 1'b0;
            rmw     <= 1'b0;
            req_len <= '0;
        end else begin
            case (state)
                line_bridge_pkg::idle: begin
                    rmw <= 1'b0;
                    // Write address wins over a read offered in the same cycle
                    if (i_aw_valid) begin
                        writing <= 1'b1;
                        req_len <= i_aw_len;
                        state   <= line_bridge_pkg::write_data_accept;
                    end else if (i_ar_valid) begin
                        writing <= 1'b0;
                        req_len <= i_ar_len;
                        state   <= line_bridge_pkg::read_line_request;
                    end
                end
                line_bridge_pkg::write_data_accept: begin
                    if (i_w_valid) begin
                        rmw   <= 1'b1;
                        state <= line_bridge_pkg::read_line_request;
                    end
                end
                line_bridge_pkg::read_line_request: begin
                    if (line.ar_ready) begin
                        state <= line_bridge_pkg::wait_read_line;
                    end
                end
                line_bridge_pkg::wait_read_line: begin
                    if (line.r_valid) begin
                        state <= rmw ? line_bridge_pkg::write_line_request
                                     : line_bridge_pkg::wait_read_accept;
                    end
                end
                line_bridge_pkg::write_line_request: begin
                    if (line.aw_ready && line.w_ready) begin
                        state <= line_bridge_pkg::wait_write_confirm;
                    end
                end
                line_bridge_pkg::wait_write_confirm: begin
                    // Every beat waits for its confirm, only the last one answers on b
                    if (line.b_valid) begin
                        state <= (req_len == '0) ? line_bridge_pkg::wait_write_accept
                                                 : line_bridge_pkg::check_burst;
                    end
                end
                line_bridge_pkg::wait_write_accept: begin
                    if (i_b_ready) begin
                        state <= line_bridge_pkg::idle;
                    end
                end
                line_bridge_pkg::wait_read_accept: begin
                    if (i_r_ready) begin
                        state <= line_bridge_pkg::check_burst;
                    end
                end
                line_bridge_pkg::check_burst: begin
                    if (req_len == '0) begin
                        state <= line_bridge_pkg::idle;
                    end else begin
                        req_len <= req_len - 1'b1;
                        rmw     <= 1'b0;
                        state   <= writing ? line_bridge_pkg::write_data_accept
                                           : line_bridge_pkg::read_line_request;
                    end
                end
                default: state <= line_bridge_pkg::idle;
            endcase
        end
    end

    // Request payload and line buffers
    always_ff @(posedge i_clk) begin
        if (state == line_bridge_pkg::idle && i_aw_valid) begin
            req_id   <= i_aw_id;
            req_addr <= i_aw_addr;
            req_size <= i_aw_size;
        end else if (state == line_bridge_pkg::idle && i_ar_valid) begin
            req_id   <= i_ar_id;
            req_addr <= i_ar_addr;
            req_size <= i_ar_size;
        end else if (state == line_bridge_pkg::check_burst && req_len != '0) begin
            // Next beat stays in the same 4 KB page
            req_addr[11:0] <= req_addr[11:0] + line_bridge_pkg::size_to_bytes(req_size);
        end
        if (o_w_ready && i_w_valid) begin
            req_wdata <= i_w_data;
            req_wstrb <= i_w_strb;
        end
        if (line.r_ready && line.r_valid) begin
            line_data <= merged_line;
            resp_data <= line.r_data[word_idx*WB +: WB];
        end
    end

    // An accepted request closes both address channels on the next cycle
    a_addr_closed: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_aw_ready && (i_aw_valid || i_ar_valid)) |=> (!o_aw_ready && !o_ar_ready));

    a_r_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_r_valid && !i_r_ready) |=>
            (o_r_valid && $stable(o_r_data) && $stable(o_r_id) && $stable(o_r_last)));

endmodule

/* rtl/line_store.sv */
// Line-wide storage behind the line bus.
// STORE_LINES must be a power of two of at least 2; addresses wrap modulo the store.
// Reads answer READ_LATENCY cycles after the request (at least 1).

`timescale 1ns/1ps

module line_store #(
    parameter int LINE_BYTES   = 32,
    parameter int STORE_LINES  = 64,
    parameter int READ_LATENCY = 2
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    line_bus_if.store  line
);

    localparam int LINE_OFF = $clog2(LINE_BYTES);
    localparam int IDX_BITS = $clog2(STORE_LINES);
    localparam int CNT_BITS = $clog2(READ_LATENCY + 1);

    logic [LINE_BYTES*8-1:0] mem [STORE_LINES];
    logic [LINE_BYTES*8-1:0] rd_line;
    logic [IDX_BITS-1:0]     rd_idx;
    logic [IDX_BITS-1:0]     wr_idx;
    logic [CNT_BITS-1:0]     rd_count;
    logic                    rd_busy;
    logic                    b_pending;
    logic                    rd_hs;
    logic                    wr_hs;

    assign rd_idx = line.ar_addr[LINE_OFF +: IDX_BITS];
    assign wr_idx = line.aw_addr[LINE_OFF +: IDX_BITS];
    assign rd_hs  = line.ar_valid && line.ar_ready;
    assign wr_hs  = line.aw_valid && line.w_valid && line.aw_ready && line.w_ready;

    assign line.ar_ready = !rd_busy;
    assign line.r_valid  = rd_busy && (rd_count == '0);
    assign line.r_data   = rd_line;
    assign line.aw_ready = !b_pending;
    assign line.w_ready  = !b_pending;
    assign line.b_valid  = b_pending;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_busy   <= 1'b0;
            rd_count  <= '0;
            b_pending <= 1'b0;
        end else begin
            // Read countdown, then hold the line until taken
            if (rd_hs) begin
                rd_busy  <= 1'b1;
                rd_count <= CNT_BITS'(READ_LATENCY - 1);
            end else if (line.r_valid && line.r_ready) begin
                rd_busy <= 1'b0;
            end else if (rd_busy && rd_count != '0) begin
                rd_count <= rd_count - 1'b1;
            end
            if (wr_hs) begin
                b_pending <= 1'b1;
            end else if (line.b_ready) begin
                b_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_hs) begin
            rd_line <= mem[rd_idx];
        end
        if (wr_hs) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (line.w_strb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= line.w_data[b*8 +: 8];
                end
            end
        end
    end

    a_addr_in_range: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (line.ar_valid || line.aw_valid) |->
            ((!line.ar_valid || (line.ar_addr >> LINE_OFF) < STORE_LINES) &&
             (!line.aw_valid || (line.aw_addr >> LINE_OFF) < STORE_LINES)));

endmodule

/* rtl/line_mem_top.sv */
// Word-port memory subsystem: AXI-style slave bridge in front of a line store.
// One transaction at a time, INCR bursts only, no error responses.
// Keep addresses below STORE_LINES * LINE_BYTES.

`timescale 1ns/1ps

module line_mem_top #(
    parameter int LINE_BYTES   = 32,
    parameter int STORE_LINES  = 64,
    parameter int READ_LATENCY = 2
) (
    input  logic                                    i_clk,
    input  logic                                    i_nrst,
    input  logic                                    i_aw_valid,
    output logic                                    o_aw_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]     i_aw_id,
    input  logic [line_bridge_pkg::ADDR_BITS-1:0]   i_aw_addr,
    input  logic [line_bridge_pkg::SIZE_BITS-1:0]   i_aw_size,
    input  logic [line_bridge_pkg::LEN_BITS-1:0]    i_aw_len,
    input  logic                                    i_w_valid,
    output logic                                    o_w_ready,
    input  logic [line_bridge_pkg::WORD_BITS-1:0]   i_w_data,
    input  logic [line_bridge_pkg::WORD_BITS/8-1:0] i_w_strb,
    output logic                                    o_b_valid,
    input  logic                                    i_b_ready,
    output logic [line_bridge_pkg::ID_BITS-1:0]     o_b_id,
    input  logic                                    i_ar_valid,
    output logic                                    o_ar_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]     i_ar_id,
    input  logic [line_bridge_pkg::ADDR_BITS-1:0]   i_ar_addr,
    input  logic [line_bridge_pkg::SIZE_BITS-1:0]   i_ar_size,
    input  logic [line_bridge_pkg::LEN_BITS-1:0]    i_ar_len,
    output logic                                    o_r_valid,
    input  logic                                    i_r_ready,
    output logic [line_bridge_pkg::ID_BITS-1:0]     o_r_id,
    output logic [line_bridge_pkg::WORD_BITS-1:0]   o_r_data,
    output logic                                    o_r_last
);

    line_bus_if #(.LINE_BYTES(LINE_BYTES)) line_bus ();

    // Slave ports share their names with the bridge, only the line bus is explicit
    word_to_line_bridge #(
        .LINE_BYTES(LINE_BYTES)
    ) bridge_inst (
        .line(line_bus),
        .*
    );

    line_store #(
        .LINE_BYTES  (LINE_BYTES),
        .STORE_LINES (STORE_LINES),
        .READ_LATENCY(READ_LATENCY)
    ) store_inst (
        .i_clk (i_clk),
        .i_nrst(i_nrst),
        .line  (line_bus)
    );

endmodule

/* sim/line_mem_checker.sv */
// Watches the DUT ports and keeps a byte-level model of every written byte.
// Handshakes are sampled on the falling clock edge, where all channels are stable.
// INCR bursts only; beat addresses step inside a 4 KB page, byte lanes follow addr[2:0].

`timescale 1ns/1ps

module line_mem_checker (
    input  logic                                    i_clk,
    input  logic                                    i_nrst,
    input  logic                                    i_aw_valid,
    input  logic                                    i_aw_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]     i_aw_id,
    input  logic [line_bridge_pkg::ADDR_BITS-1:0]   i_aw_addr,
    input  logic [line_bridge_pkg::SIZE_BITS-1:0]   i_aw_size,
    input  logic [line_bridge_pkg::LEN_BITS-1:0]    i_aw_len,
    input  logic                                    i_w_valid,
    input  logic                                    i_w_ready,
    input  logic [line_bridge_pkg::WORD_BITS-1:0]   i_w_data,
    input  logic [line_bridge_pkg::WORD_BITS/8-1:0] i_w_strb,
    input  logic                                    i_b_valid,
    input  logic                                    i_b_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]     i_b_id,
    input  logic                                    i_ar_valid,
    input  logic                                    i_ar_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]     i_ar_id,
    input  logic [line_bridge_pkg::ADDR_BITS-1:0]   i_ar_addr,
    input  logic [line_bridge_pkg::SIZE_BITS-1:0]   i_ar_size,
    input  logic [line_bridge_pkg::LEN_BITS-1:0]    i_ar_len,
    input  logic                                    i_r_valid,
    input  logic                                    i_r_ready,
    input  logic [line_bridge_pkg::ID_BITS-1:0]     i_r_id,
    input  logic [line_bridge_pkg::WORD_BITS-1:0]   i_r_data,
    input  logic                                    i_r_last,
    output int                                      o_err_count,
    output int                                      o_open_count
);

    typedef struct packed {
        logic [line_bridge_pkg::ID_BITS-1:0]   id;
        logic [line_bridge_pkg::ADDR_BITS-1:0] addr;
        logic [line_bridge_pkg::SIZE_BITS-1:0] size;
        logic [8:0]                            beats;
    } xfer_t;

    logic [7:0] model [int unsigned];
    xfer_t      wr_q [$];
    xfer_t      rd_q [$];
    int         errors = 0;

    task automatic report_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    always @(negedge i_clk) begin : watch
        xfer_t       cur;
        logic [31:0] base;
        logic [63:0] exp_word;
        logic        missing;
        if (i_nrst) begin
            if (i_aw_valid && i_aw_ready) begin
                cur = '{i_aw_id, i_aw_addr, i_aw_size, 9'(i_aw_len) + 9'd1};
                wr_q.push_back(cur);
            end
            if (i_w_valid && i_w_ready) begin
                if (wr_q.size() == 0 || wr_q[0].beats == 9'd0) begin
                    report_error("write data beat arrived outside any open write burst");
                end else begin
                    cur = wr_q[0];
                    base = {cur.addr[31:3], 3'b000};
                    for (int b = 0; b < 8; b++) begin
                        if (i_w_strb[b]) begin
                            model[base + b] = i_w_data[b*8 +: 8];
                        end
                    end
                    cur.addr[11:0] = cur.addr[11:0] + (12'd1 << cur.size);
                    cur.beats = cur.beats - 9'd1;
                    wr_q[0] = cur;
                end
            end
            if (i_b_valid && i_b_ready) begin
                if (wr_q.size() == 0) begin
                    report_error("write response with no open write");
                end else begin
                    cur = wr_q.pop_front();
                    if (i_b_id !== cur.id) begin
                        report_error($sformatf("b id %0h, expected %0h", i_b_id, cur.id));
                    end
                    if (cur.beats != 9'd0) begin
                        report_error("write response came before all data beats");
                    end
                end
            end
            // In idle the write address wins, so a read offered beside it is not taken
            if (i_ar_valid && i_ar_ready && !i_aw_valid) begin
                cur = '{i_ar_id, i_ar_addr, i_ar_size, 9'(i_ar_len) + 9'd1};
                rd_q.push_back(cur);
            end
            if (i_r_valid && i_r_ready) begin
                if (rd_q.size() == 0) begin
                    report_error("read data beat with no open read");
                end else begin
                    cur = rd_q[0];
                    base = {cur.addr[31:3], 3'b000};
                    missing = 1'b0;
                    exp_word = '0;
                    for (int b = 0; b < 8; b++) begin
                        if (model.exists(base + b)) begin
                            exp_word[b*8 +: 8] = model[base + b];
                        end else begin
                            missing = 1'b1;
                        end
                    end
                    if (missing) begin
                        report_error($sformatf("read of unwritten bytes at %h", base));
                    end else if (i_r_data !== exp_word) begin
                        report_error($sformatf("r data %h at %h, expected %h",
                                               i_r_data, base, exp_word));
                    end
                    if (i_r_id !== cur.id) begin
                        report_error($sformatf("r id %0h, expected %0h", i_r_id, cur.id));
                    end
                    if (i_r_last !== (cur.beats == 9'd1)) begin
                        report_error($sformatf("r last %b with %0d beats left",
                                               i_r_last, cur.beats));
                    end
                    cur.addr[11:0] = cur.addr[11:0] + (12'd1 << cur.size);
                    cur.beats = cur.beats - 9'd1;
                    if (cur.beats == 9'd0) begin
                        void'(rd_q.pop_front());
                    end else begin
                        rd_q[0] = cur;
                    end
                end
            end
        end
        o_err_count  = errors;
        o_open_count = wr_q.size() + rd_q.size();
    end

endmodule

/* sim/tb_line_mem_top.sv */
// Drives the memory subsystem from a stimulus table, one entry at a time.
// Inputs change 1 ns after the rising edge; b and r ready are random.
// All beats are 8 bytes; addresses stay inside the default 2 KB store.

`timescale 1ns/1ps

module tb_line_mem_top;

    localparam int         NUM_ENTRIES = 13;
    localparam logic [1:0] OP_WR       = 2'd0;
    localparam logic [1:0] OP_RD       = 2'd1;
    localparam logic [1:0] OP_WR_RD    = 2'd2;

    typedef struct packed {
        logic [1:0]                            op;
        logic [line_bridge_pkg::ID_BITS-1:0]   id;
        logic [line_bridge_pkg::ADDR_BITS-1:0] addr;
        logic [line_bridge_pkg::LEN_BITS-1:0]  len;
        logic [3:0][63:0]                      data;
        logic [3:0][7:0]                       strb;
    } stim_t;

    logic                                    i_clk;
    logic                                    i_nrst;
    logic                                    i_aw_valid;
    logic                                    o_aw_ready;
    logic [line_bridge_pkg::ID_BITS-1:0]     i_aw_id;
    logic [line_bridge_pkg::ADDR_BITS-1:0]   i_aw_addr;
    logic [line_bridge_pkg::SIZE_BITS-1:0]   i_aw_size;
    logic [line_bridge_pkg::LEN_BITS-1:0]    i_aw_len;
    logic                                    i_w_valid;
    logic                                    o_w_ready;
    logic [line_bridge_pkg::WORD_BITS-1:0]   i_w_data;
    logic [line_bridge_pkg::WORD_BITS/8-1:0] i_w_strb;
    logic                                    o_b_valid;
    logic                                    i_b_ready;
    logic [line_bridge_pkg::ID_BITS-1:0]     o_b_id;
    logic                                    i_ar_valid;
    logic                                    o_ar_ready;
    logic [line_bridge_pkg::ID_BITS-1:0]     i_ar_id;
    logic [line_bridge_pkg::ADDR_BITS-1:0]   i_ar_addr;
    logic [line_bridge_pkg::SIZE_BITS-1:0]   i_ar_size;
    logic [line_bridge_pkg::LEN_BITS-1:0]    i_ar_len;
    logic                                    o_r_valid;
    logic                                    i_r_ready;
    logic [line_bridge_pkg::ID_BITS-1:0]     o_r_id;
    logic [line_bridge_pkg::WORD_BITS-1:0]   o_r_data;
    logic                                    o_r_last;
    int                                      err_count;
    int                                      open_count;
    stim_t                                   stim [NUM_ENTRIES];

    line_mem_top #(
        .LINE_BYTES  (32),
        .STORE_LINES (64),
        .READ_LATENCY(2)
    ) line_mem_top_inst (.*);

    line_mem_checker checker_inst (
        .i_aw_ready  (o_aw_ready),
        .i_w_ready   (o_w_ready),
        .i_b_valid   (o_b_valid),
        .i_b_id      (o_b_id),
        .i_ar_ready  (o_ar_ready),
        .i_r_valid   (o_r_valid),
        .i_r_id      (o_r_id),
        .i_r_data    (o_r_data),
        .i_r_last    (o_r_last),
        .o_err_count (err_count),
        .o_open_count(open_count),
        .*
    );

    always #5 i_clk = ~i_clk;

    // Random back-pressure on both response channels
    always @(posedge i_clk) begin
        #1;
        i_b_ready = ($urandom % 4) != 0;
        i_r_ready = ($urandom % 4) != 0;
    end

    // Address, data beats, then the single b response
    task automatic send_write(input stim_t e);
        i_aw_valid = 1'b1;
        i_aw_id    = e.id;
        i_aw_addr  = e.addr;
        i_aw_size  = 3'd3;
        i_aw_len   = e.len;
        @(negedge i_clk);
        while (!o_aw_ready) @(negedge i_clk);
        @(posedge i_clk);
        #1;
        i_aw_valid = 1'b0;
        for (int k = 0; k <= int'(e.len); k++) begin
            i_w_valid = 1'b1;
            i_w_data  = e.data[k];
            i_w_strb  = e.strb[k];
            @(negedge i_clk);
            while (!o_w_ready) @(negedge i_clk);
            @(posedge i_clk);
            #1;
            i_w_valid = 1'b0;
        end
        @(negedge i_clk);
        while (!(o_b_valid && i_b_ready)) @(negedge i_clk);
        @(posedge i_clk);
        #1;
    endtask

    task automatic send_read(input logic [3:0] id, input logic [31:0] addr,
                             input logic [7:0] len);
        i_ar_valid = 1'b1;
        i_ar_id    = id;
        i_ar_addr  = addr;
        i_ar_size  = 3'd3;
        i_ar_len   = len;
        // A write address offered in the same cycle is served first
        @(negedge i_clk);
        while (!(o_ar_ready && !i_aw_valid)) @(negedge i_clk);
        @(posedge i_clk);
        #1;
        i_ar_valid = 1'b0;
        @(negedge i_clk);
        while (!(o_r_valid && i_r_ready && o_r_last)) @(negedge i_clk);
        @(posedge i_clk);
        #1;
    endtask

    initial begin
        i_clk      = 1'b0;
        i_nrst     = 1'b0;
        i_aw_valid = 1'b0;
        i_aw_id    = '0;
        i_aw_addr  = '0;
        i_aw_size  = '0;
        i_aw_len   = '0;
        i_w_valid  = 1'b0;
        i_w_data   = '0;
        i_w_strb   = '0;
        i_b_ready  = 1'b0;
        i_ar_valid = 1'b0;
        i_ar_id    = '0;
        i_ar_addr  = '0;
        i_ar_size  = '0;
        i_ar_len   = '0;
        i_r_ready  = 1'b0;
        void'($urandom(32'hdb4a));

        // Single write and read back, then a partial merge
        stim[0]  = '{OP_WR, 4'h1, 32'h100, 8'd0, {192'h0, 64'h1122334455667788}, 32'hff};
        stim[1]  = '{OP_RD, 4'h2, 32'h100, 8'd0, 256'h0, 32'h0};
        stim[2]  = '{OP_WR, 4'h3, 32'h100, 8'd0, {192'h0, 64'hbeef00000000cafe}, 32'hc3};
        stim[3]  = '{OP_RD, 4'h4, 32'h100, 8'd0, 256'h0, 32'h0};
        // Other word slots of the same line
        stim[4]  = '{OP_WR, 4'h5, 32'h108, 8'd0, {192'h0, 64'h0202020202020202}, 32'hff};
        stim[5]  = '{OP_WR, 4'h6, 32'h110, 8'd0, {192'h0, 64'h0303030303030303}, 32'hff};
        stim[6]  = '{OP_WR, 4'h7, 32'h118, 8'd0, {192'h0, 64'h0404040404040404}, 32'hff};
        stim[7]  = '{OP_RD, 4'h8, 32'h100, 8'd3, 256'h0, 32'h0};
        // Four-beat bursts
        stim[8]  = '{OP_WR, 4'h9, 32'h200, 8'd3,
                     {64'hd3d3d3d3d3d3d3d3, 64'hd2d2d2d2d2d2d2d2,
                      64'hd1d1d1d1d1d1d1d1, 64'hd0d0d0d0d0d0d0d0}, 32'hffffffff};
        stim[9]  = '{OP_RD, 4'ha, 32'h200, 8'd3, 256'h0, 32'h0};
        // Write and read addresses raised together
        stim[10] = '{OP_WR_RD, 4'hb, 32'h300, 8'd0, {192'h0, 64'h5a5a0f0f5a5a0f0f}, 32'hff};
        // Burst crossing into the next line
        stim[11] = '{OP_WR, 4'hd, 32'h218, 8'd1,
                     {128'h0, 64'h7777666655554444, 64'h3333222211110000}, 32'hfff0};
        stim[12] = '{OP_RD, 4'he, 32'h210, 8'd2, 256'h0, 32'h0};

        repeat (2) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            case (stim[n].op)
                OP_WR: send_write(stim[n]);
                OP_RD: send_read(stim[n].id, stim[n].addr, stim[n].len);
                default: begin
                    fork
                        send_write(stim[n]);
                        send_read(stim[n].id + 1'b1, stim[n].addr, stim[n].len);
                    join
                end
            endcase
        end
        repeat (4) @(posedge i_clk);
        $display("Run complete: %0d errors, %0d transactions left open", err_count, open_count);
        if (err_count == 0 && open_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(NUM_ENTRIES * 300 * 10);
        $display("Timeout: the DUT stopped responding before the table was done");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* flist.f */
rtl/line_bridge_pkg.sv
rtl/line_bus_if.sv
rtl/word_to_line_bridge.sv
rtl/line_store.sv
rtl/line_mem_top.sv
sim/line_mem_checker.sv
sim/tb_line_mem_top.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench, then look for the pass line in the output
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_line_mem_top -f flist.f
out=$(./obj_dir/Vtb_line_mem_top)
echo "$out"
echo "$out" | grep -q "Testbench passed"
